// File: cdr_top.f
hw/cdr_const_pack.sv
hw/cdr_cfg_pack.sv
hw/mm_pd.sv
hw/mm_loop_filter.sv
hw/cdr_snapshot.sv
hw/cdr_top.sv
verification/cdr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CDR loop testbench with Verilator.
# Exits non-zero when the build fails, the run fails, or the log reports a failure.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cdr_tb -Mdir obj_dir -f cdr_top.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vcdr_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Regression failed" "$SIM_LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0

// File: verification/cdr_tb.sv
`default_nettype none

module cdr_tb;

    import cdr_const_pack::*;
    import cdr_cfg_pack::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 10;
    localparam int idle_cycles  = 20;
    localparam int prop_cycles  = 200;
    localparam int clamp_cycles = 150;
    localparam int loop2_cycles = 300;
    localparam int ext_cycles   = 20;
    localparam int snap_pulses  = 4;
    localparam int snap_half    = 3;
    localparam int test_cycles  = reset_cycles + idle_cycles + prop_cycles + clamp_cycles
                                + loop2_cycles + ext_cycles + snap_pulses * 2 * snap_half;

    typedef enum logic [1:0] {S_WAIT_LOW, S_READY, S_CAPTURE} snap_st_t;

    logic           clk;
    logic           ext_rstb;
    adc_code_t      codes [Nti-1:0];
    logic [Nti-1:0] bits;
    logic           ramp_clk;
    cdr_cfg_t       cfg;
    logic           sample_req;
    pi_ctl_t        pi_ctl [Nout-1:0];
    logic           freq_lvl_cross;
    cdr_snap_t      snap;

    // reference model state
    adc_code_t   m_last_code;
    logic        m_last_bit;
    pd_err_t     m_pd_err, m_err;
    logic        m_ramp_ff, m_ramp_sync;
    est_t        m_rp, m_rn, m_freq, m_phase, m_prev_fu, clamp_q;
    logic        m_lvl, step_clamped_q;
    snap_st_t    m_snap_st;
    cdr_snap_t   m_snap;
    est_t        err_w, kp_term, ki_term, kr_term, rp_next, rn_next, freq_upd, step_now;
    loop_state_t m_state;
    pi_ctl_t     exp_pi;
    logic        pi_ok;

    // pi word before the last edge and its change across that edge
    pi_ctl_t               pi_prev_q;
    logic signed [Npi-1:0] pi_step;
    est_t                  step_max;
    logic                  step_ok;

    cdr_top cdr_top_i (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .codes_i          (codes),
        .bits_i           (bits),
        .ramp_clk_i       (ramp_clk),
        .cfg_i            (cfg),
        .sample_req_i     (sample_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .snap_o           (snap)
    );

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // mueller-muller sum over one frame with bits as +1/-1
    function automatic int mm_error(input adc_code_t c [Nti-1:0], input logic [Nti-1:0] b,
                                    input adc_code_t c_prev, input logic b_prev);
        int sum;
        int left;
        int s_left;
        sum = 0;
        for (int k = 0; k < Nti; k++) begin
            if (k == 0) begin
                left   = int'(c_prev);
                s_left = b_prev ? 1 : -1;
            end else begin
                left   = int'(c[k-1]);
                s_left = b[k-1] ? 1 : -1;
            end
            sum = sum + (b[k] ? left : -left) - s_left * int'(c[k]);
        end
        return sum;
    endfunction

    always_comb begin
        err_w    = est_t'(m_err);
        kp_term  = err_w <<< cfg.kp;
        ki_term  = err_w <<< cfg.ki;
        kr_term  = err_w <<< cfg.kr;
        rp_next  = m_rp + (ramp_clk ? kr_term : est_t'(0));  // plus side on high level
        rn_next  = m_rn + (ramp_clk ? est_t'(0) : kr_term);
        freq_upd = ki_term + (m_ramp_sync ? m_rp : -m_rn);
        step_now = kp_term + m_freq;
        if (cfg.en_clamp && step_now > cfg.clamp_amt) step_now = cfg.clamp_amt;
        if (cfg.en_clamp && step_now < -cfg.clamp_amt) step_now = -cfg.clamp_amt;
        m_state.phase_out   = pi_ctl_t'(m_phase >>> phase_est_shift);
        m_state.freq_update = freq_upd;
        m_state.ramp_update = ramp_clk ? rp_next : rn_next;
        exp_pi = cfg.en_ext_pi_ctl ? cfg.ext_pi_ctl : m_state.phase_out;
        pi_ok  = 1'b1;
        for (int k = 0; k < Nout; k++) begin
            if (pi_ctl[k] != exp_pi) pi_ok = 1'b0;
        end
        pi_step  = pi_ctl[0] - pi_prev_q;  // wraps like the pi word
        // a step of at most clamp_amt moves the integer phase by this much
        step_max = (clamp_q >>> phase_est_shift) + 1;
        step_ok  = est_t'(pi_step) <= step_max && est_t'(pi_step) >= -step_max;
    end

    always @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            {m_last_code, m_last_bit, m_pd_err, m_err} <= '0;
            {m_ramp_ff, m_ramp_sync, m_rp, m_rn, m_freq, m_phase} <= '0;
            {m_prev_fu, pi_prev_q, clamp_q, m_lvl, step_clamped_q} <= '0;
            m_snap_st <= S_WAIT_LOW;
            m_snap    <= '0;
        end else begin
            m_last_code    <= codes[Nti-1];
            m_last_bit     <= bits[Nti-1];
            m_pd_err       <= pd_err_t'(mm_error(codes, bits, m_last_code, m_last_bit)
                                        + int'(cfg.pd_offset));
            m_err          <= -m_pd_err;  // loop sees the negated error
            m_ramp_ff      <= ramp_clk;
            m_ramp_sync    <= m_ramp_ff;
            m_rp           <= cfg.en_ramp_est ? rp_next : est_t'(0);
            m_rn           <= cfg.en_ramp_est ? rn_next : est_t'(0);
            m_freq         <= cfg.en_freq_est ? m_freq + freq_upd : m_freq;
            m_prev_fu      <= freq_upd;
            m_lvl          <= freq_upd > m_prev_fu;
            m_phase        <= m_phase + step_now;
            pi_prev_q      <= pi_ctl[0];
            clamp_q        <= cfg.clamp_amt;
            step_clamped_q <= cfg.en_clamp;
            case (m_snap_st)
                S_WAIT_LOW: if (!sample_req) m_snap_st <= S_READY;
                S_READY:    if (sample_req) m_snap_st <= S_CAPTURE;
                default: begin
                    m_snap    <= cdr_snap_t'(m_state);
                    m_snap_st <= S_WAIT_LOW;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // checks sampled on the falling edge
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string what);
        $display("mismatch at time %0t: %s", $time, what);
        $display("Regression failed");
        $fatal(1, "stopping on first error");
    endtask

    assert property (@(negedge clk) disable iff (!ext_rstb) pi_ok)
        else report_mismatch("pi_ctl_o differs from the model");
    assert property (@(negedge clk) disable iff (!ext_rstb) freq_lvl_cross == m_lvl)
        else report_mismatch("freq_lvl_cross_o differs from the model");
    assert property (@(negedge clk) disable iff (!ext_rstb) snap == m_snap)
        else report_mismatch("snap_o differs from the model");
    assert property (@(negedge clk) disable iff (!ext_rstb) !step_clamped_q || step_ok)
        else report_mismatch("pi_ctl_o step exceeds clamp_amt");

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic drive_frame(input bit random_data);
        @(posedge clk);
        #2;
        for (int k = 0; k < Nti; k++) begin
            codes[k] = random_data ? adc_code_t'($urandom) : adc_code_t'(0);
            bits[k]  = random_data ? ~codes[k][Nadc-1] : 1'b0;  // slicer decision
        end
    endtask

    initial begin
        #((test_cycles + 100) * clk_period);
        $display("timeout: the test did not finish within %0d cycles", test_cycles + 100);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hd67b));
        clk        = 1'b0;
        ext_rstb   = 1'b0;
        bits       = '0;
        ramp_clk   = 1'b0;
        cfg        = '0;
        sample_req = 1'b0;
        for (int k = 0; k < Nti; k++) codes[k] = '0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        ext_rstb = 1'b1;

        repeat (idle_cycles) drive_frame(1'b0);  // quiet loop stays at zero

        cfg.kp = 4'd4;  // proportional only
        repeat (prop_cycles) drive_frame(1'b1);

        cfg.kp        = 4'd10;
        cfg.en_clamp  = 1'b1;
        cfg.clamp_amt = est_t'(2000);
        repeat (clamp_cycles) drive_frame(1'b1);

        // second order loop with ramp estimator
        cfg.en_clamp    = 1'b0;
        cfg.kp          = 4'd4;
        cfg.ki          = 4'd1;
        cfg.kr          = 4'd0;
        cfg.en_freq_est = 1'b1;
        cfg.en_ramp_est = 1'b1;
        cfg.pd_offset   = pd_err_t'(3);
        for (int i = 0; i < loop2_cycles; i++) begin
            drive_frame(1'b1);
            ramp_clk = i[3];
        end

        cfg.en_ext_pi_ctl = 1'b1;
        cfg.ext_pi_ctl    = 8'h5a;
        repeat (ext_cycles) drive_frame(1'b1);
        cfg.en_ext_pi_ctl = 1'b0;

        for (int p = 0; p < snap_pulses; p++) begin
            sample_req = 1'b0;
            repeat (snap_half) drive_frame(1'b1);
            sample_req = 1'b1;
            repeat (snap_half) drive_frame(1'b1);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/cdr_top.sv
`default_nettype none

module cdr_top (
    input  wire logic                           clk,
    input  wire logic                           ext_rstb,
    input  wire cdr_const_pack::adc_code_t      codes_i [cdr_const_pack::Nti-1:0],
    input  wire logic [cdr_const_pack::Nti-1:0] bits_i,
    input  wire logic                           ramp_clk_i,
    input  wire cdr_cfg_pack::cdr_cfg_t         cfg_i,
    input  wire logic                           sample_req_i,
    output cdr_const_pack::pi_ctl_t             pi_ctl_o [cdr_const_pack::Nout-1:0],
    output logic                                freq_lvl_cross_o,
    output cdr_cfg_pack::cdr_snap_t             snap_o
);

    import cdr_const_pack::*;
    import cdr_cfg_pack::*;

    pd_err_t     pd_err;        // detector to loop filter
    loop_state_t loop_state;    // loop filter to snapshot

    mm_pd mm_pd_i (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .codes_i     (codes_i),
        .bits_i      (bits_i),
        .pd_offset_i (cfg_i.pd_offset),
        .pd_err_o    (pd_err)
    );

    mm_loop_filter mm_loop_filter_i (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .pd_err_i         (pd_err),
        .ramp_clk_i       (ramp_clk_i),
        .cfg_i            (cfg_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .state_o          (loop_state)
    );

    cdr_snapshot cdr_snapshot_i (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .state_i      (loop_state),
        .snap_o       (snap_o)
    );

endmodule

`default_nettype wire

// File: hw/cdr_snapshot.sv
`default_nettype none

module cdr_snapshot (
    input  wire logic                      clk,
    input  wire logic                      ext_rstb,
    input  wire logic                      sample_req_i,
    input  wire cdr_cfg_pack::loop_state_t state_i,
    output cdr_cfg_pack::cdr_snap_t        snap_o
);

    typedef enum logic [1:0] {
        WAIT_LOW,   // need request low first
        READY,      // armed, wait for request high
        CAPTURE
    } snap_state_t;

    snap_state_t snap_state;

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            snap_state <= WAIT_LOW;
            snap_o     <= '0;
        end else begin
            case (snap_state)
                WAIT_LOW: begin
                    if (!sample_req_i) snap_state <= READY;
                end
                READY: begin
                    if (sample_req_i) snap_state <= CAPTURE;
                end
                CAPTURE: begin
                    snap_o.phase_out   <= state_i.phase_out;
                    snap_o.freq_update <= state_i.freq_update;
                    snap_o.ramp_update <= state_i.ramp_update;
                    snap_state         <= WAIT_LOW;  // one capture per pulse
                end
                default: snap_state <= WAIT_LOW;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/mm_loop_filter.sv
`default_nettype none

module mm_loop_filter (
    input  wire logic                      clk,
    input  wire logic                      ext_rstb,
    input  wire cdr_const_pack::pd_err_t   pd_err_i,
    input  wire logic                      ramp_clk_i,
    input  wire cdr_cfg_pack::cdr_cfg_t    cfg_i,
    output cdr_const_pack::pi_ctl_t        pi_ctl_o [cdr_const_pack::Nout-1:0],
    output logic                           freq_lvl_cross_o,
    output cdr_cfg_pack::loop_state_t      state_o
);

    import cdr_const_pack::*;

    pd_err_t err_q;             // negated detector error
    logic    ramp_clk_ff;
    logic    ramp_clk_sync;

    est_t    err_ext;
    est_t    err_kp;
    est_t    err_ki;
    est_t    err_kr;

    est_t    ramp_pls_q, ramp_pls_upd, ramp_pls_d;
    est_t    ramp_neg_q, ramp_neg_upd, ramp_neg_d;
    est_t    ramp_update;

    est_t    freq_q, freq_d, freq_update;
    est_t    prev_freq_update_q;

    est_t    phase_q, phase_d;
    est_t    phase_update, phase_clamped;
    est_t    phase_shifted;
    pi_ctl_t phase_out;

    //////////////////////////////////////////////////
    // scaled error terms
    //////////////////////////////////////////////////

    assign err_ext = est_t'(err_q);     // sign extend to accumulator width
    assign err_kp  = err_ext <<< cfg_i.kp;
    assign err_ki  = err_ext <<< cfg_i.ki;
    assign err_kr  = err_ext <<< cfg_i.kr;

    //////////////////////////////////////////////////
    // ramp estimator
    //////////////////////////////////////////////////

    always_comb begin
        ramp_pls_upd = ramp_pls_q + (ramp_clk_i ? err_kr : '0);
        ramp_neg_upd = ramp_neg_q + (ramp_clk_i ? '0 : err_kr);
        ramp_pls_d   = cfg_i.en_ramp_est ? ramp_pls_upd : '0;
        ramp_neg_d   = cfg_i.en_ramp_est ? ramp_neg_upd : '0;
        ramp_update  = ramp_clk_i ? ramp_pls_upd : ramp_neg_upd;
    end

    //////////////////////////////////////////////////
    // frequency and phase paths
    //////////////////////////////////////////////////

    always_comb begin
        freq_update = err_ki + (ramp_clk_sync ? ramp_pls_q : -ramp_neg_q);
        freq_d      = freq_q + (cfg_i.en_freq_est ? freq_update : '0);

        phase_update = err_kp + freq_q;

        // limit per-cycle step to +/- clamp_amt
        phase_clamped = phase_update;
        if (cfg_i.en_clamp) begin
            if (phase_update > cfg_i.clamp_amt) begin
                phase_clamped = cfg_i.clamp_amt;
            end else if (phase_update < -cfg_i.clamp_amt) begin
                phase_clamped = -cfg_i.clamp_amt;
            end
        end

        phase_d = phase_q + phase_clamped;
    end

    assign phase_shifted = phase_q >>> phase_est_shift;
    assign phase_out     = phase_shifted[Npi-1:0];  // integer part, truncated

    always_comb begin
        for (int k = 0; k < Nout; k++) begin
            pi_ctl_o[k] = cfg_i.en_ext_pi_ctl ? cfg_i.ext_pi_ctl : phase_out;
        end
    end

    assign state_o.phase_out   = phase_out;
    assign state_o.freq_update = freq_update;
    assign state_o.ramp_update = ramp_update;

    //////////////////////////////////////////////////
    // state registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            err_q              <= '0;
            ramp_clk_ff        <= 1'b0;
            ramp_clk_sync      <= 1'b0;
            ramp_pls_q         <= '0;
            ramp_neg_q         <= '0;
            freq_q             <= '0;
            prev_freq_update_q <= '0;
            phase_q            <= '0;
            freq_lvl_cross_o   <= 1'b0;
        end else begin
            err_q              <= -pd_err_i;  // loop runs on the inverted error
            ramp_clk_ff        <= ramp_clk_i;
            ramp_clk_sync      <= ramp_clk_ff;
            ramp_pls_q         <= ramp_pls_d;
            ramp_neg_q         <= ramp_neg_d;
            freq_q             <= freq_d;
            prev_freq_update_q <= freq_update;
            phase_q            <= phase_d;
            freq_lvl_cross_o   <= (freq_update > prev_freq_update_q);
        end
    end

endmodule

`default_nettype wire

// File: hw/mm_pd.sv
`default_nettype none

module mm_pd (
    input  wire logic                           clk,
    input  wire logic                           ext_rstb,
    input  wire cdr_const_pack::adc_code_t      codes_i [cdr_const_pack::Nti-1:0],
    input  wire logic [cdr_const_pack::Nti-1:0] bits_i,
    input  wire cdr_const_pack::pd_err_t        pd_offset_i,
    output cdr_const_pack::pd_err_t             pd_err_o
);

    import cdr_const_pack::*;

    adc_code_t      last_code_q;  // lane Nti-1 of the previous frame
    logic           last_bit_q;

    // lane list with the held neighbor at index 0
    adc_code_t      code_ext [Nti:0];
    logic [Nti:0]   bit_ext;
    pd_err_t        pd_sum;

    always_comb begin
        code_ext[0] = last_code_q;
        bit_ext[0]  = last_bit_q;
        for (int k = 0; k < Nti; k++) begin
            code_ext[k+1] = codes_i[k];
            bit_ext[k+1]  = bits_i[k];
        end
    end

    // mueller-muller sum, bits taken as +1/-1
    always_comb begin
        pd_err_t early;
        pd_err_t late;
        pd_sum = '0;
        for (int k = 0; k < Nti; k++) begin
            early  = pd_err_t'(code_ext[k]);    // code(k-1)
            late   = pd_err_t'(code_ext[k+1]);  // code(k)
            pd_sum = pd_sum + (bit_ext[k+1] ? early : -early)
                            - (bit_ext[k]   ? late  : -late);
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_code_q <= '0;
            last_bit_q  <= 1'b0;
            pd_err_o    <= '0;
        end else begin
            last_code_q <= codes_i[Nti-1];
            last_bit_q  <= bits_i[Nti-1];
            pd_err_o    <= pd_sum + pd_offset_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/cdr_cfg_pack.sv
`default_nettype none

package cdr_cfg_pack;

    import cdr_const_pack::*;

    //////////////////////////////////////////////////
    // static loop configuration
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [gain_width-1:0] kp;  // proportional shift
        logic [gain_width-1:0] ki;  // integral shift
        logic [gain_width-1:0] kr;  // ramp shift
        logic                  en_freq_est;
        logic                  en_ramp_est;
        logic                  en_clamp;
        logic                  en_ext_pi_ctl;
        est_t                  clamp_amt;   // non-negative
        pd_err_t               pd_offset;
        pi_ctl_t               ext_pi_ctl;
    } cdr_cfg_t;

    // live loop values offered to the snapshot
    typedef struct packed {
        pi_ctl_t phase_out;
        est_t    freq_update;
        est_t    ramp_update;
    } loop_state_t;

    // held copy for readout
    typedef struct packed {
        pi_ctl_t phase_out;
        est_t    freq_update;
        est_t    ramp_update;
    } cdr_snap_t;

endpackage

`default_nettype wire

// File: hw/cdr_const_pack.sv
`default_nettype none

package cdr_const_pack;

    //////////////////////////////////////////////////
    // datapath sizes
    //////////////////////////////////////////////////

    localparam int Nadc            = 8;   // adc code width
    localparam int Nti             = 4;   // interleaved lanes per frame
    localparam int Npi             = 8;   // pi control width
    localparam int Nout            = 2;   // pi outputs
    localparam int phase_est_shift = 12;  // fraction bits of phase accumulator

    localparam int gain_width   = 4;
    localparam int pd_err_width = Nadc + 4;
    localparam int est_width    = pd_err_width + phase_est_shift + 2;

    // scalar words
    typedef logic signed [Nadc-1:0]         adc_code_t;
    typedef logic signed [pd_err_width-1:0] pd_err_t;
    typedef logic signed [est_width-1:0]    est_t;
    typedef logic        [Npi-1:0]          pi_ctl_t;

endpackage

`default_nettype wire
